/* hdl/riscv_fetch_pkg.sv */
// shared widths, bus encodings, opcodes and parcel formats for the fetch front end
package riscv_fetch_pkg;

  //////////////////////////////////////////////////
  // sizes
  localparam int          xlen     = 32;
  // first fetch after reset
  localparam logic [31:0] reset_pc = 32'h0000_0000;

  //////////////////////////////////////////////////
  // bus encodings
  typedef enum logic [2:0] {
    size_byte  = 3'd0,
    size_hword = 3'd1,
    size_word  = 3'd2,
    size_dword = 3'd3
  } biu_size_t;

  // burst types, only single used here
  typedef enum logic [2:0] {
    type_single = 3'd0,
    type_incr   = 3'd1,
    type_wrap4  = 3'd2,
    type_incr4  = 3'd3
  } biu_type_t;

  //////////////////////////////////////////////////
  // parcel classes
  typedef enum logic [3:0] {
    cls_alu_imm = 4'd0,
    cls_alu_reg = 4'd1,
    cls_load    = 4'd2,
    cls_store   = 4'd3,
    cls_branch  = 4'd4,
    cls_jal     = 4'd5,
    cls_jalr    = 4'd6,
    cls_lui     = 4'd7,
    cls_auipc   = 4'd8,
    cls_illegal = 4'd9
  } instr_class_t;

  // major opcodes, low two bits always 11
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;

  //////////////////////////////////////////////////
  // one parcel, seen through each immediate format
  typedef union packed {
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_fmt;
    struct packed {
      logic [6:0]  imm_hi;
      logic [4:0]  rs2;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  imm_lo;
      logic [6:0]  opcode;
    } s_fmt;
    // branch offset is scattered, bit 0 implied zero
    struct packed {
      logic        imm12;
      logic [5:0]  imm10_5;
      logic [4:0]  rs2;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [3:0]  imm4_1;
      logic        imm11;
      logic [6:0]  opcode;
    } b_fmt;
    struct packed {
      logic [19:0] imm;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u_fmt;
    struct packed {
      logic        imm20;
      logic [9:0]  imm10_1;
      logic        imm11;
      logic [7:0]  imm19_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } j_fmt;
  } riscv_instr_u;

endpackage

/* hdl/riscv_pc_gen.sv */
// next fetch address sequencer, feeds the no-icache fetch core
`timescale 1ns/1ps

module riscv_pc_gen (
  input  logic        clk,
  input  logic        rstn,
  input  logic        if_stall_nxt_pc,
  input  logic        jal_redirect,
  input  logic [31:0] jal_target,
  output logic [31:0] if_nxt_pc
);
  import riscv_fetch_pkg::*;

  //////////////////////////////////////////////////
  // pc register
  //////////////////////////////////////////////////

  // redirect wins over stall, the flush drops the pending fetch anyway
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      if_nxt_pc <= reset_pc;
    end else if (jal_redirect) begin
      if_nxt_pc <= jal_target;
    end else if (!if_stall_nxt_pc) begin
      // one word per accepted strobe
      if_nxt_pc <= if_nxt_pc + 32'd4;
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // no compressed parcels, so every fetch and jal target is a word address
  a_pc_word_aligned : assert property (
    @(posedge clk) disable iff (!rstn)
    if_nxt_pc[1:0] == 2'b00
  );

endmodule

/* hdl/riscv_noicache_core.sv */
// fetch strobe generation and 3-entry parcel queue between the biu and the cpu side
`timescale 1ns/1ps

module riscv_noicache_core (
  input  logic                        clk,
  input  logic                        rstn,

  // cpu side
  input  logic                        if_stall,
  input  logic                        if_flush,
  input  logic                        dcflush_rdy,
  input  logic [1:0]                  st_prv,
  input  logic [31:0]                 if_nxt_pc,
  output logic                        if_stall_nxt_pc,
  output logic                        if_parcel_valid,
  output logic                        if_parcel_misaligned,
  output logic [31:0]                 if_parcel_pc,
  output logic [31:0]                 if_parcel,

  // biu side
  input  logic                        biu_stb_ack,
  input  logic                        biu_ack,
  input  logic                        biu_err,
  input  logic [31:0]                 biu_adro,
  input  logic [31:0]                 biu_do,
  output logic                        biu_stb,
  output logic                        biu_lock,
  output logic                        biu_we,
  output logic                        biu_is_cacheable,
  output logic                        biu_is_instruction,
  output logic [31:0]                 biu_adri,
  output logic [31:0]                 biu_di,
  output riscv_fetch_pkg::biu_size_t  biu_size,
  output riscv_fetch_pkg::biu_type_t  biu_type,
  output logic [1:0]                  biu_prv
);
  import riscv_fetch_pkg::*;

  logic        if_flush_dly;
  logic        stb_issue;
  // strobes acked but not yet answered
  logic [1:0]  stb_cnt;

  // queue, entry 0 faces the cpu
  logic [2:0]  fifo_valid;
  logic [31:0] fifo_dat [3];
  logic [31:0] fifo_adr [3];
  logic [2:0]  vld_shift;
  logic [1:0]  wr_slot;

  //////////////////////////////////////////////////
  // cpu side
  //////////////////////////////////////////////////

  // one cycle of quiet after a redirect
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      if_flush_dly <= 1'b0;
    end else begin
      if_flush_dly <= if_flush;
    end
  end

  // pc only moves on an accepted strobe
  assign if_stall_nxt_pc = ~stb_issue;

  // the flushing parcel itself still goes out
  assign if_parcel_valid = dcflush_rdy & ~if_flush_dly & ~if_stall & fifo_valid[0];
  assign if_parcel_pc    = fifo_adr[0];
  assign if_parcel       = fifo_dat[0];

  // 16-bit parcels not supported
  assign if_parcel_misaligned = |fifo_adr[0][1:0];

  //////////////////////////////////////////////////
  // biu side
  //////////////////////////////////////////////////

  // hold off once two parcels wait, keeps queue plus in-flight within 3
  assign biu_stb   = dcflush_rdy & ~if_flush & ~if_stall & ~fifo_valid[1];
  assign stb_issue = biu_stb & biu_stb_ack;
  assign biu_adri  = if_nxt_pc;
  assign biu_size  = (xlen == 64) ? size_dword : size_word;
  assign biu_type  = type_single;
  assign biu_lock  = 1'b0;
  // read only port
  assign biu_we    = 1'b0;
  assign biu_di    = '0;

  // top half of the map is io, not cacheable
  assign biu_is_cacheable   = ~if_nxt_pc[31];
  assign biu_is_instruction = 1'b1;
  assign biu_prv            = st_prv;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      stb_cnt <= 2'd0;
    end else if (if_flush) begin
      // replies still in flight come back stale and unacked
      stb_cnt <= 2'd0;
    end else begin
      stb_cnt <= stb_cnt + {1'b0, stb_issue} - {1'b0, biu_ack};
    end
  end

  //////////////////////////////////////////////////
  // parcel queue
  //////////////////////////////////////////////////

  // valid bits after a possible read, then first free slot
  always_comb begin
    vld_shift = if_parcel_valid ? {1'b0, fifo_valid[2:1]} : fifo_valid;
    if (!vld_shift[0]) begin
      wr_slot = 2'd0;
    end else if (!vld_shift[1]) begin
      wr_slot = 2'd1;
    end else begin
      wr_slot = 2'd2;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      fifo_valid <= 3'b000;
    end else if (if_flush) begin
      fifo_valid <= 3'b000;
    end else begin
      fifo_valid <= vld_shift;
      if (biu_ack) begin
        fifo_valid[wr_slot] <= 1'b1;
      end
    end
  end

  // payload, the write lands after the shift
  always_ff @(posedge clk) begin
    if (if_parcel_valid) begin
      for (int i = 0; i < 2; i++) begin
        fifo_dat[i] <= fifo_dat[i+1];
        fifo_adr[i] <= fifo_adr[i+1];
      end
    end
    if (biu_ack) begin
      fifo_dat[wr_slot] <= biu_do;
      fifo_adr[wr_slot] <= biu_adro;
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // strobe throttle must keep the queue from overflowing
  a_no_overflow : assert property (
    @(posedge clk) disable iff (!rstn)
    biu_ack |-> !fifo_valid[2]
  );

  // biu answers only strobes it took since the last flush
  a_ack_for_strobe : assert property (
    @(posedge clk) disable iff (!rstn)
    biu_ack |-> stb_cnt != 2'd0
  );

  // no error path in this fetch unit
  a_no_bus_error : assert property (
    @(posedge clk) disable iff (!rstn)
    !biu_err
  );

endmodule

/* hdl/riscv_biu.sv */
// bus interface unit, turns fetch strobes into single word reads on the memory bus
`timescale 1ns/1ps

module riscv_biu (
  input  logic        clk,
  input  logic        rstn,
  input  logic        biu_stb,
  input  logic        if_flush,
  input  logic        mem_ack,
  input  logic [31:0] biu_adri,
  input  logic [31:0] mem_rdata,
  output logic        biu_stb_ack,
  output logic        biu_ack,
  output logic        mem_req,
  output logic [31:0] biu_adro,
  output logic [31:0] biu_do,
  output logic [31:0] mem_adr
);

  // outstanding reads, entry 0 is the oldest
  logic [1:0]  out_cnt;
  logic [31:0] adr_q [2];
  logic [1:0]  stale_q;
  logic [1:0]  stale_nxt;
  logic        push;
  logic        pop;
  // slot for a new read after a possible pop
  logic        wr_idx;
  // low in reset and the first cycle after it, no read goes out then
  logic        req_en;

  //////////////////////////////////////////////////
  // request side
  //////////////////////////////////////////////////

  assign biu_stb_ack = req_en & (out_cnt < 2'd2);
  assign push        = biu_stb & biu_stb_ack;
  assign mem_req     = push;
  assign mem_adr     = biu_adri;

  //////////////////////////////////////////////////
  // reply side
  //////////////////////////////////////////////////

  // replies come in request order
  assign pop      = mem_ack;
  assign biu_do   = mem_rdata;
  assign biu_adro = adr_q[0];
  // reply racing the flush is dropped too
  assign biu_ack  = mem_ack & ~stale_q[0] & ~if_flush;

  // push only with at most one entry, so a pop leaves slot 0 free
  assign wr_idx = out_cnt[0] & ~pop;

  always_comb begin
    stale_nxt = pop ? {1'b0, stale_q[1]} : stale_q;
    // flush marks everything in flight
    if (if_flush) begin
      stale_nxt = 2'b11;
    end
    if (push) begin
      stale_nxt[wr_idx] = if_flush;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      out_cnt <= 2'd0;
      stale_q <= 2'b00;
      req_en  <= 1'b0;
    end else begin
      out_cnt <= out_cnt + {1'b0, push} - {1'b0, pop};
      stale_q <= stale_nxt;
      req_en  <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      adr_q[0] <= adr_q[1];
    end
    if (push) begin
      adr_q[wr_idx] <= biu_adri;
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // memory answers only what was asked
  a_ack_outstanding : assert property (
    @(posedge clk) disable iff (!rstn)
    mem_ack |-> out_cnt != 2'd0
  );

endmodule

/* hdl/riscv_parcel_decode.sv */
// parcel decode into class and immediate, raises the jal redirect toward fetch
`timescale 1ns/1ps

module riscv_parcel_decode (
  input  logic                          clk,
  input  logic                          rstn,
  input  logic                          if_parcel_valid,
  input  logic                          if_parcel_misaligned,
  input  logic [31:0]                   if_parcel_pc,
  input  logic [31:0]                   if_parcel,
  output logic                          dec_valid,
  output logic                          jal_redirect,
  output logic [31:0]                   dec_pc,
  output logic [31:0]                   dec_parcel,
  output logic [31:0]                   dec_imm,
  output logic [31:0]                   jal_target,
  output riscv_fetch_pkg::instr_class_t dec_class
);
  import riscv_fetch_pkg::*;

  riscv_instr_u instr;
  // sign extended immediates per format
  logic [31:0]  imm_i;
  logic [31:0]  imm_s;
  logic [31:0]  imm_b;
  logic [31:0]  imm_u;
  logic [31:0]  imm_j;

  assign instr = if_parcel;

  //////////////////////////////////////////////////
  // immediates
  //////////////////////////////////////////////////

  assign imm_i = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
  assign imm_s = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
  assign imm_b = {{19{instr.b_fmt.imm12}}, instr.b_fmt.imm12, instr.b_fmt.imm11,
                  instr.b_fmt.imm10_5, instr.b_fmt.imm4_1, 1'b0};
  // upper immediate, low 12 bits zero
  assign imm_u = {instr.u_fmt.imm, 12'h000};
  assign imm_j = {{11{instr.j_fmt.imm20}}, instr.j_fmt.imm20, instr.j_fmt.imm19_12,
                  instr.j_fmt.imm11, instr.j_fmt.imm10_1, 1'b0};

  //////////////////////////////////////////////////
  // classify
  //////////////////////////////////////////////////

  always_comb begin
    dec_class = cls_illegal;
    dec_imm   = '0;
    case (instr.i_fmt.opcode)
      opc_op_imm: begin
        dec_class = cls_alu_imm;
        dec_imm   = imm_i;
      end
      // register ops carry no immediate
      opc_op: begin
        dec_class = cls_alu_reg;
      end
      opc_load: begin
        dec_class = cls_load;
        dec_imm   = imm_i;
      end
      opc_store: begin
        dec_class = cls_store;
        dec_imm   = imm_s;
      end
      opc_branch: begin
        dec_class = cls_branch;
        dec_imm   = imm_b;
      end
      opc_jal: begin
        dec_class = cls_jal;
        dec_imm   = imm_j;
      end
      opc_jalr: begin
        dec_class = cls_jalr;
        dec_imm   = imm_i;
      end
      opc_lui: begin
        dec_class = cls_lui;
        dec_imm   = imm_u;
      end
      opc_auipc: begin
        dec_class = cls_auipc;
        dec_imm   = imm_u;
      end
      default: begin
        dec_class = cls_illegal;
      end
    endcase
    // misaligned fetch never executes
    if (if_parcel_misaligned) begin
      dec_class = cls_illegal;
      dec_imm   = '0;
    end
  end

  assign dec_valid  = if_parcel_valid;
  assign dec_pc     = if_parcel_pc;
  assign dec_parcel = if_parcel;

  //////////////////////////////////////////////////
  // jal redirect
  //////////////////////////////////////////////////

  assign jal_target   = if_parcel_pc + imm_j;
  assign jal_redirect = if_parcel_valid & (dec_class == cls_jal);

  // fetch flush must hide whatever followed the jal
  a_flush_after_jal : assert property (
    @(posedge clk) disable iff (!rstn)
    jal_redirect |=> !dec_valid
  );

endmodule

/* hdl/riscv_retire.sv */
// retire register for decoded parcels, with a running count of retirements
`timescale 1ns/1ps

module riscv_retire (
  input  logic                          clk,
  input  logic                          rstn,
  input  logic                          dec_valid,
  input  logic [31:0]                   dec_pc,
  input  logic [31:0]                   dec_parcel,
  input  logic [31:0]                   dec_imm,
  input  riscv_fetch_pkg::instr_class_t dec_class,
  output logic                          ret_valid,
  output logic [31:0]                   ret_pc,
  output logic [31:0]                   ret_parcel,
  output logic [31:0]                   ret_imm,
  output riscv_fetch_pkg::instr_class_t ret_class,
  output logic [15:0]                   ret_count
);

  //////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////

  // count moves with ret_valid, so it includes the parcel on the outputs
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      ret_valid <= 1'b0;
      ret_count <= 16'd0;
    end else begin
      ret_valid <= dec_valid;
      if (dec_valid) begin
        ret_count <= ret_count + 16'd1;
      end
    end
  end

  //////////////////////////////////////////////////
  // payload
  //////////////////////////////////////////////////

  // holds last retired parcel between valids
  always_ff @(posedge clk) begin
    if (dec_valid) begin
      ret_pc     <= dec_pc;
      ret_parcel <= dec_parcel;
      ret_imm    <= dec_imm;
      ret_class  <= dec_class;
    end
  end

endmodule

/* hdl/riscv_fetch_top.sv */
// fetch front end top level, memory bus in and retire trace out
`timescale 1ns/1ps

module riscv_fetch_top (
  input  logic                          clk,
  input  logic                          rstn,
  input  logic                          mem_ack,
  input  logic [31:0]                   mem_rdata,
  output logic                          mem_req,
  output logic                          ret_valid,
  output logic [31:0]                   mem_adr,
  output logic [31:0]                   ret_pc,
  output logic [31:0]                   ret_parcel,
  output logic [31:0]                   ret_imm,
  output riscv_fetch_pkg::instr_class_t ret_class,
  output logic [15:0]                   ret_count
);
  import riscv_fetch_pkg::*;

  // pc and redirect
  logic         if_stall_nxt_pc;
  logic         jal_redirect;
  logic [31:0]  if_nxt_pc;
  logic [31:0]  jal_target;

  // fetch core to biu
  logic         biu_stb;
  logic         biu_stb_ack;
  logic         biu_ack;
  logic [31:0]  biu_adri;
  logic [31:0]  biu_adro;
  logic [31:0]  biu_do;

  // parcels to decode
  logic         if_parcel_valid;
  logic         if_parcel_misaligned;
  logic [31:0]  if_parcel_pc;
  logic [31:0]  if_parcel;

  // decode to retire
  logic         dec_valid;
  logic [31:0]  dec_pc;
  logic [31:0]  dec_parcel;
  logic [31:0]  dec_imm;
  instr_class_t dec_class;

  //////////////////////////////////////////////////
  // fetch
  //////////////////////////////////////////////////

  riscv_pc_gen u_pc_gen (
    .clk             (clk),
    .rstn            (rstn),
    .if_stall_nxt_pc (if_stall_nxt_pc),
    .jal_redirect    (jal_redirect),
    .jal_target      (jal_target),
    .if_nxt_pc       (if_nxt_pc)
  );

  // no dcache, machine mode only, retire never stalls
  riscv_noicache_core u_noicache_core (
    .clk                  (clk),
    .rstn                 (rstn),
    .if_stall             (1'b0),
    .if_flush             (jal_redirect),
    .dcflush_rdy          (1'b1),
    .st_prv               (2'b11),
    .if_nxt_pc            (if_nxt_pc),
    .if_stall_nxt_pc      (if_stall_nxt_pc),
    .if_parcel_valid      (if_parcel_valid),
    .if_parcel_misaligned (if_parcel_misaligned),
    .if_parcel_pc         (if_parcel_pc),
    .if_parcel            (if_parcel),
    .biu_stb_ack          (biu_stb_ack),
    .biu_ack              (biu_ack),
    .biu_err              (1'b0),
    .biu_adro             (biu_adro),
    .biu_do               (biu_do),
    .biu_stb              (biu_stb),
    .biu_lock             (),
    .biu_we               (),
    .biu_is_cacheable     (),
    .biu_is_instruction   (),
    .biu_adri             (biu_adri),
    .biu_di               (),
    .biu_size             (),
    .biu_type             (),
    .biu_prv              ()
  );

  riscv_biu u_biu (
    .clk         (clk),
    .rstn        (rstn),
    .biu_stb     (biu_stb),
    .if_flush    (jal_redirect),
    .mem_ack     (mem_ack),
    .biu_adri    (biu_adri),
    .mem_rdata   (mem_rdata),
    .biu_stb_ack (biu_stb_ack),
    .biu_ack     (biu_ack),
    .mem_req     (mem_req),
    .biu_adro    (biu_adro),
    .biu_do      (biu_do),
    .mem_adr     (mem_adr)
  );

  //////////////////////////////////////////////////
  // decode and retire
  //////////////////////////////////////////////////

  riscv_parcel_decode u_parcel_decode (
    .clk                  (clk),
    .rstn                 (rstn),
    .if_parcel_valid      (if_parcel_valid),
    .if_parcel_misaligned (if_parcel_misaligned),
    .if_parcel_pc         (if_parcel_pc),
    .if_parcel            (if_parcel),
    .dec_valid            (dec_valid),
    .jal_redirect         (jal_redirect),
    .dec_pc               (dec_pc),
    .dec_parcel           (dec_parcel),
    .dec_imm              (dec_imm),
    .jal_target           (jal_target),
    .dec_class            (dec_class)
  );

  riscv_retire u_retire (
    .clk        (clk),
    .rstn       (rstn),
    .dec_valid  (dec_valid),
    .dec_pc     (dec_pc),
    .dec_parcel (dec_parcel),
    .dec_imm    (dec_imm),
    .dec_class  (dec_class),
    .ret_valid  (ret_valid),
    .ret_pc     (ret_pc),
    .ret_parcel (ret_parcel),
    .ret_imm    (ret_imm),
    .ret_class  (ret_class),
    .ret_count  (ret_count)
  );

endmodule

/* verification/riscv_fetch_tb.sv */
// testbench for the fetch front end, replays the program and retire trace of the pattern file
`timescale 1ns/1ps

module riscv_fetch_tb;
  import riscv_fetch_pkg::*;

  // cycles allowed between two retirements
  localparam int wait_max = 200;
  // trace section, count word then 4 words per record
  localparam int trace_base = 64;

  logic         clk;
  logic         rstn;
  logic         mem_ack;
  logic [31:0]  mem_rdata;
  logic         mem_req;
  logic         ret_valid;
  logic [31:0]  mem_adr;
  logic [31:0]  ret_pc;
  logic [31:0]  ret_parcel;
  logic [31:0]  ret_imm;
  instr_class_t ret_class;
  logic [15:0]  ret_count;

  // program at word 0, expected trace from word 64
  logic [31:0]  pat [256];
  integer       seed;
  int           errors;
  int           checks;

  riscv_fetch_top DUT (
    .clk        (clk),
    .rstn       (rstn),
    .mem_ack    (mem_ack),
    .mem_rdata  (mem_rdata),
    .mem_req    (mem_req),
    .ret_valid  (ret_valid),
    .mem_adr    (mem_adr),
    .ret_pc     (ret_pc),
    .ret_parcel (ret_parcel),
    .ret_imm    (ret_imm),
    .ret_class  (ret_class),
    .ret_count  (ret_count)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  // program region from the file, anything above it a fill word
  function automatic logic [31:0] mem_word(input logic [31:0] adr);
    if (adr < 32'h100) begin
      return pat[{2'b00, adr[7:2]}];
    end
    return adr ^ 32'h5a5a_a5a5;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  // next falling edge with ret_valid high, bounded
  task automatic wait_retire(output bit seen);
    int n;
    seen = 1'b0;
    n    = 0;
    while (!seen && n < wait_max) begin
      @(negedge clk);
      seen = ret_valid;
      n++;
    end
  endtask

  //////////////////////////////////////////////////
  // reset and memory model
  //////////////////////////////////////////////////

  // one process, so release of reset and the first request never race
  initial begin
    int          delay;
    int          cyc;
    logic [31:0] req_adr [$];
    int          req_due [$];
    seed      = 32'h1700;
    cyc       = 0;
    rstn      = 1'b0;
    mem_ack   = 1'b0;
    mem_rdata = 32'h0;
    repeat (3) begin
      @(negedge clk);
    end
    rstn = 1'b1;
    forever begin
      cyc++;
      // reply of last cycle was taken at the rising edge
      if (mem_ack) begin
        void'(req_adr.pop_front());
        void'(req_due.pop_front());
      end
      mem_ack = 1'b0;
      if (mem_req) begin
        checks++;
        assert (req_adr.size() < 2) else begin
          $display("mem_req raised while two reads were already outstanding");
          errors++;
        end
        delay = 1 + int'($unsigned($random(seed)) % 3);
        req_adr.push_back(mem_adr);
        req_due.push_back(cyc + delay);
      end
      // in order, oldest first
      if (req_adr.size() > 0 && cyc >= req_due[0]) begin
        mem_ack   = 1'b1;
        mem_rdata = mem_word(req_adr[0]);
      end
      @(negedge clk);
    end
  end

  //////////////////////////////////////////////////
  // trace checker
  //////////////////////////////////////////////////

  initial begin
    int nrec;
    int base;
    bit seen;
    bit timed_out;
    errors    = 0;
    checks    = 0;
    timed_out = 1'b0;
    // fill depends on the full word index
    for (int i = 0; i < 256; i++) begin
      pat[i] = 32'h0bad_0000 | i;
    end
    $readmemh("verification/fetch_patterns.hex", pat);
    nrec = int'(pat[trace_base]);

    // outputs quiet in reset and right after
    repeat (3) begin
      @(negedge clk);
      check_value("reset mem_req", 32'd0, {31'd0, mem_req});
      check_value("reset ret_valid", 32'd0, {31'd0, ret_valid});
      check_value("reset ret_count", 32'd0, {16'd0, ret_count});
    end
    @(negedge clk);
    check_value("after reset ret_valid", 32'd0, {31'd0, ret_valid});
    check_value("after reset ret_count", 32'd0, {16'd0, ret_count});

    checks++;
    assert (nrec > 0 && nrec <= 47) else begin
      $display("trace record count in the pattern file is missing or out of range");
      errors++;
      nrec = 0;
    end

    for (int r = 0; r < nrec && !timed_out; r++) begin
      base = trace_base + 1 + 4 * r;
      wait_retire(seen);
      if (!seen) begin
        $display("no retirement within %0d cycles while waiting for record %0d", wait_max, r);
        errors++;
        timed_out = 1'b1;
      end else begin
        check_value($sformatf("record %0d pc", r), pat[base], ret_pc);
        check_value($sformatf("record %0d parcel", r), pat[base+1], ret_parcel);
        check_value($sformatf("record %0d class", r), pat[base+2], {28'd0, ret_class});
        check_value($sformatf("record %0d imm", r), pat[base+3], ret_imm);
        // count includes the parcel on the outputs
        if (r == nrec - 1) begin
          check_value("retire count", 32'(nrec), {16'd0, ret_count});
        end
      end
    end

    $display("errors %0d in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* verification/fetch_patterns.hex */
// program words from @00, one 32-bit word per line at word address pc/4
// trace from @40: record count, then one record per line as pc parcel class imm
@00
00500093 // addi x1, x0, 5
00108133 // add  x2, x1, x1
FFC12183 // lw   x3, -4(x2)
00312423 // sw   x3, 8(x2)
FE208CE3 // beq  x1, x2, -8
123452B7 // lui  x5, 0x12345
FFFFF317 // auipc x6, 0xfffff
01008067 // jalr x0, 16(x1)
020000EF // jal  x1, +0x20
@10
00000000 // illegal
FFF40413 // addi x8, x8, -1
FF9FF06F // jal  x0, -8
@40
0000000F
00000000 00500093 00000000 00000005
00000004 00108133 00000001 00000000
00000008 FFC12183 00000002 FFFFFFFC
0000000C 00312423 00000003 00000008
00000010 FE208CE3 00000004 FFFFFFF8
00000014 123452B7 00000007 12345000
00000018 FFFFF317 00000008 FFFFF000
0000001C 01008067 00000006 00000010
00000020 020000EF 00000005 00000020
00000040 00000000 00000009 00000000
00000044 FFF40413 00000000 FFFFFFFF
00000048 FF9FF06F 00000005 FFFFFFF8
00000040 00000000 00000009 00000000
00000044 FFF40413 00000000 FFFFFFFF
00000048 FF9FF06F 00000005 FFFFFFF8

/* list.f */
hdl/riscv_fetch_pkg.sv
hdl/riscv_pc_gen.sv
hdl/riscv_noicache_core.sv
hdl/riscv_biu.sv
hdl/riscv_parcel_decode.sv
hdl/riscv_retire.sv
hdl/riscv_fetch_top.sv
verification/riscv_fetch_tb.sv

/* Makefile */
SRCS := $(shell cat list.f)

.PHONY: run clean

run: obj_dir/Vriscv_fetch_tb
	@out="$$(./obj_dir/Vriscv_fetch_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

obj_dir/Vriscv_fetch_tb: list.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  -f list.f --top-module riscv_fetch_tb -o Vriscv_fetch_tb

clean:
	rm -rf obj_dir
